// ==== ind_btb.f ====
+incdir+tests
hw/ind_btb_pkg.sv
hw/ind_btb_inv_ctrl.sv
hw/ind_btb_retire_path.sv
hw/ind_btb_spec_path.sv
hw/ind_btb_access_ctrl.sv
hw/ind_btb_array.sv
hw/ind_btb_dout_reg.sv
hw/ind_btb_top.sv
tests/ind_btb_tb.sv

// ==== Makefile ====
# Verilator flow for the indirect btb testbench

VERILATOR ?= verilator
TOP       ?= ind_btb_tb
FILELIST  ?= ind_btb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

SRCS := $(shell grep -v '^+' $(FILELIST)) tests/ind_btb_model.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/ind_btb_model.svh ====
// indirect btb reference model
`ifndef ind_btb_model_svh
`define ind_btb_model_svh

// ========================================
// model state
// ========================================
ind_btb_pkg::path_hist_t ref_rtu_hist;
ind_btb_pkg::path_hist_t ref_spec_hist;
ind_btb_pkg::btb_entry_t ref_mem [256];
ind_btb_pkg::btb_entry_t ref_rdata;
ind_btb_pkg::btb_entry_t ref_dout;
logic [1:0]              ref_priv;
logic                    ref_rd_flop;
logic                    ref_inv_on;
logic                    ref_inv_ack;
logic [7:0]              ref_inv_cnt;

// bit pair k from stage k, then xor with ghr
function automatic logic [7:0] table_index(input ind_btb_pkg::path_hist_t h,
                                           input logic [7:0] ghr);
  return {h.stage[3][7:6], h.stage[2][5:4], h.stage[1][3:2], h.stage[0][1:0]} ^ ghr;
endfunction

// newest index lands in stage 0
function automatic ind_btb_pkg::path_hist_t push_index(input ind_btb_pkg::path_hist_t h,
                                                       input logic [7:0] idx);
  return {h.stage[2:0], idx};
endfunction

task automatic reset_model();
  ref_rtu_hist  = '0;
  ref_spec_hist = '0;
  ref_rdata     = '0;
  ref_dout      = '0;
  ref_priv      = ind_btb_pkg::priv_machine;
  ref_rd_flop   = 1'b0;
  ref_inv_on    = 1'b0;
  ref_inv_ack   = 1'b0;
  ref_inv_cnt   = 8'd0;
  for (int i = 0; i < 256; i++)
    ref_mem[i] = '0;
endtask

// one clock edge, inputs as sampled by the DUT
task automatic step_model();
  ind_btb_pkg::path_hist_t rtu_nxt;
  ind_btb_pkg::path_hist_t spec_nxt;
  ind_btb_pkg::btb_entry_t wdata;
  logic [7:0]              idx;
  logic                    wen;
  logic                    ren;
  logic                    any_jmp;
  logic                    start;
  // retire slots shift in oldest first
  rtu_nxt = ref_rtu_hist;
  any_jmp = 1'b0;
  for (int s = 0; s < 3; s++)
  begin
    if (retire.slot[s].jmp)
    begin
      rtu_nxt = push_index(rtu_nxt, retire.slot[s].chk_idx);
      any_jmp = 1'b1;
    end
  end
  if (flush || retire.mispred)
    spec_nxt = rtu_nxt;
  else if (fetch.check_vld)
    spec_nxt = push_index(ref_spec_hist, fetch.path);
  else
    spec_nxt = ref_spec_hist;
  // sweep, then write, then read
  wen   = 1'b0;
  ren   = 1'b0;
  idx   = 8'd0;
  wdata = '0;
  if (ref_inv_on)
  begin
    wen = 1'b1;
    idx = ref_inv_cnt;
  end
  else if (btb_en && retire.jmp_mispred)
  begin
    wen   = 1'b1;
    idx   = table_index(ref_rtu_hist, rtu_ghr);
    wdata = {1'b1, priv_mode, retire.target};
  end
  else if (btb_en && !fifo_stall && (fetch.jmp_detect || fetch.check_vld))
  begin
    ren = 1'b1;
    idx = table_index(spec_nxt, vghr);
  end
  // output pipe, data lands one edge after the table read
  if (ref_rd_flop && !ref_inv_on)
  begin
    ref_dout = ref_rdata;
    ref_priv = priv_mode;
  end
  ref_rd_flop = ref_inv_on ? 1'b0 : ren;
  if (ren)
    ref_rdata = ref_mem[idx];
  if (wen)
    ref_mem[idx] = wdata;
  // histories
  if (ref_inv_on)
  begin
    ref_rtu_hist  = '0;
    ref_spec_hist = '0;
  end
  else if (btb_en)
  begin
    if (any_jmp)
      ref_rtu_hist = rtu_nxt;
    if (flush || retire.mispred || fetch.check_vld)
      ref_spec_hist = spec_nxt;
  end
  // sweep counter and four-phase ack
  start = inv_req && !ref_inv_ack && !ref_inv_on;
  if (ref_inv_on && ref_inv_cnt == 8'd0)
  begin
    ref_inv_on  = 1'b0;
    ref_inv_ack = 1'b1;
  end
  else
  begin
    if (!inv_req)
      ref_inv_ack = 1'b0;
    if (start)
    begin
      ref_inv_on  = 1'b1;
      ref_inv_cnt = 8'hff;
    end
    else if (ref_inv_on)
      ref_inv_cnt = ref_inv_cnt - 8'd1;
  end
endtask

`endif

// ==== tests/ind_btb_tb.sv ====
// indirect btb testbench
`timescale 1ns/1ps

module ind_btb_tb;

  localparam int sweep_len = 256;
  localparam int n_clean   = 100;
  localparam int n_mixed   = 1500;
  localparam int n_tail    = 500;
  localparam int n_off     = 200;
  // reset, two sweeps with handshake slack, all traffic phases
  localparam int run_cycles = 10 + 2 * (sweep_len + 8) + n_clean + n_mixed + 2 * n_tail + n_off;

  logic                    dout_update_clk;
  logic                    cpurst_b;
  logic                    btb_en;
  logic                    inv_req;
  logic                    flush;
  logic                    fifo_stall;
  ind_btb_pkg::retire_bus_t retire;
  ind_btb_pkg::fetch_bus_t  fetch;
  logic [7:0]              rtu_ghr;
  logic [7:0]              vghr;
  logic [1:0]              priv_mode;
  ind_btb_pkg::btb_entry_t dout;
  logic [1:0]              priv_out;
  logic                    inv_on;
  logic                    inv_ack;

  integer                  seed;
  int                      errors;
  ind_btb_pkg::path_hist_t rtu_save;
  ind_btb_pkg::path_hist_t spec_save;
  ind_btb_pkg::btb_entry_t mem_save [256];

  `include "ind_btb_model.svh"

  ind_btb_top ind_btb_top_inst (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .btb_en          (btb_en),
    .inv_req         (inv_req),
    .flush           (flush),
    .fifo_stall      (fifo_stall),
    .retire          (retire),
    .fetch           (fetch),
    .rtu_ghr         (rtu_ghr),
    .vghr            (vghr),
    .priv_mode       (priv_mode),
    .dout            (dout),
    .priv_out        (priv_out),
    .inv_on          (inv_on),
    .inv_ack         (inv_ack)
  );

  // 8 ns period
  always #4 dout_update_clk = ~dout_update_clk;

  // ========================================
  // helpers
  // ========================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic idle_inputs();
    btb_en     = 1'b0;
    flush      = 1'b0;
    fifo_stall = 1'b0;
    retire     = '0;
    fetch      = '0;
    rtu_ghr    = 8'd0;
    vghr       = 8'd0;
    priv_mode  = 2'd0;
  endtask

  // everything except inv_req
  task automatic drive_random(input logic en);
    logic [31:0] r;
    logic [31:0] q;
    r = $random(seed);
    q = $random(seed);
    btb_en             = en;
    flush              = (r[3:0] == 4'd0);
    fifo_stall         = (r[6:4] == 3'd0);
    retire.mispred     = (r[9:7] == 3'd0);
    retire.jmp_mispred = (r[11:10] == 2'd0);
    fetch.jmp_detect   = r[12];
    fetch.check_vld    = r[13];
    priv_mode          = r[15:14];
    rtu_ghr            = r[23:16];
    vghr               = r[31:24];
    retire.target      = q[19:0];
    fetch.path         = q[27:20];
    for (int s = 0; s < 3; s++)
    begin
      r = $random(seed);
      retire.slot[s].jmp     = r[8];
      retire.slot[s].chk_idx = r[7:0];
    end
  endtask

  // advance one edge, step the model and compare
  task automatic next_cycle();
    @(posedge dout_update_clk);
    #1;
    step_model();
    check_value("inv_on", 32'(inv_on), 32'(ref_inv_on));
    check_value("inv_ack", 32'(inv_ack), 32'(ref_inv_ack));
    check_value("dout", 32'(dout), 32'(ref_dout));
    check_value("priv_out", 32'(priv_out), 32'(ref_priv));
    check_value("rtu_hist", 32'(ind_btb_top_inst.rtu_hist), 32'(ref_rtu_hist));
    check_value("spec_hist", 32'(ind_btb_top_inst.ind_btb_spec_path_inst.spec_hist),
                32'(ref_spec_hist));
  endtask

  // full req/ack cycle, optionally with traffic that gets blocked
  task automatic run_sweep(input logic traffic);
    int on_cycles;
    int waited;
    on_cycles = 0;
    waited    = 0;
    inv_req   = 1'b1;
    while (!inv_ack)
    begin
      next_cycle();
      if (inv_on)
        on_cycles++;
      waited++;
      if (waited > sweep_len + 8)
      begin
        $display("invalidation acknowledge never arrived");
        $display("ERRORS FOUND");
        $fatal(1, "sweep handshake timeout");
      end
      if (traffic)
        drive_random(1'b1);
    end
    check_value("inv_on cycles", 32'(on_cycles), 32'(sweep_len));
    inv_req = 1'b0;
    next_cycle();
    check_value("inv_ack after release", 32'(inv_ack), 32'd0);
  endtask

  // ========================================
  // watchdog
  // ========================================
  initial
  begin
    #(run_cycles * 8 * 2);
    $display("simulation ran past its time limit");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  // ========================================
  // main sequence
  // ========================================
  initial
  begin
    dout_update_clk = 1'b0;
    cpurst_b        = 1'b0;
    inv_req         = 1'b0;
    seed            = 32'h84a8;
    errors          = 0;
    idle_inputs();
    reset_model();
    repeat (10) @(posedge dout_update_clk);
    #1;
    // values straight out of reset
    check_value("inv_on", 32'(inv_on), 32'd0);
    check_value("inv_ack", 32'(inv_ack), 32'd0);
    check_value("dout", 32'(dout), 32'd0);
    check_value("priv_out", 32'(priv_out), 32'(ind_btb_pkg::priv_machine));
    cpurst_b = 1'b1;
    // table is undefined until the first sweep
    run_sweep(1'b0);
    // no writes, every hit must be a zero entry
    repeat (n_clean)
    begin
      drive_random(1'b1);
      retire.jmp_mispred = 1'b0;
      next_cycle();
      check_value("dout after sweep", 32'(dout), 32'd0);
    end
    repeat (n_mixed)
    begin
      drive_random(1'b1);
      next_cycle();
    end
    run_sweep(1'b1);
    repeat (n_tail)
    begin
      drive_random(1'b1);
      next_cycle();
    end
    // disabled predictor freezes histories and table
    rtu_save  = ref_rtu_hist;
    spec_save = ref_spec_hist;
    mem_save  = ref_mem;
    repeat (n_off)
    begin
      drive_random(1'b0);
      next_cycle();
    end
    check_value("rtu_hist while disabled", 32'(ind_btb_top_inst.rtu_hist), 32'(rtu_save));
    check_value("spec_hist while disabled",
                32'(ind_btb_top_inst.ind_btb_spec_path_inst.spec_hist), 32'(spec_save));
    for (int i = 0; i < 256; i++)
      check_value("table entry while disabled",
                  32'(ind_btb_top_inst.ind_btb_array_inst.mem[i]), 32'(mem_save[i]));
    repeat (n_tail)
    begin
      drive_random(1'b1);
      next_cycle();
    end
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== hw/ind_btb_top.sv ====
// indirect btb top level
`timescale 1ns/1ps

module ind_btb_top #(
  parameter int index_w = ind_btb_pkg::index_w
) (
  input  logic                     dout_update_clk,
  input  logic                     cpurst_b,
  input  logic                     btb_en,
  input  logic                     inv_req,
  input  logic                     flush,
  input  logic                     fifo_stall,
  input  ind_btb_pkg::retire_bus_t retire,
  input  ind_btb_pkg::fetch_bus_t  fetch,
  input  logic [index_w-1:0]       rtu_ghr,
  input  logic [index_w-1:0]       vghr,
  input  logic [1:0]               priv_mode,
  output ind_btb_pkg::btb_entry_t  dout,
  output logic [1:0]               priv_out,
  output logic                     inv_on,
  output logic                     inv_ack
);

  // ========================================
  // internal wires
  // ========================================
  logic [index_w-1:0]      inv_idx;
  ind_btb_pkg::path_hist_t rtu_hist;
  ind_btb_pkg::path_hist_t rtu_hist_next;
  ind_btb_pkg::path_hist_t spec_hist_next;
  ind_btb_pkg::btb_cmd_t   cmd;
  ind_btb_pkg::btb_entry_t rdata;
  logic                    rd_issue;

  // invalidation sweep and its handshake
  ind_btb_inv_ctrl #(.index_w(index_w)) ind_btb_inv_ctrl_inst (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .inv_req         (inv_req),
    .inv_on          (inv_on),
    .inv_ack         (inv_ack),
    .inv_idx         (inv_idx)
  );

  // ========================================
  // input side, path histories
  // ========================================
  ind_btb_retire_path ind_btb_retire_path_inst (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .retire          (retire),
    .btb_en          (btb_en),
    .inv_on          (inv_on),
    .rtu_hist        (rtu_hist),
    .rtu_hist_next   (rtu_hist_next)
  );

  ind_btb_spec_path ind_btb_spec_path_inst (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .fetch           (fetch),
    .flush           (flush),
    .retire_mispred  (retire.mispred),
    .btb_en          (btb_en),
    .inv_on          (inv_on),
    .rtu_hist_next   (rtu_hist_next),
    .spec_hist_next  (spec_hist_next)
  );

  // ========================================
  // table access and storage
  // ========================================
  ind_btb_access_ctrl #(.index_w(index_w)) ind_btb_access_ctrl_inst (
    .retire         (retire),
    .fetch          (fetch),
    .flush          (flush),
    .btb_en         (btb_en),
    .fifo_stall     (fifo_stall),
    .inv_on         (inv_on),
    .inv_idx        (inv_idx),
    .rtu_hist       (rtu_hist),
    .spec_hist_next (spec_hist_next),
    .rtu_ghr        (rtu_ghr),
    .vghr           (vghr),
    .priv_mode      (priv_mode),
    .cmd            (cmd),
    .rd_issue       (rd_issue)
  );

  ind_btb_array #(.index_w(index_w)) ind_btb_array_inst (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .cmd             (cmd),
    .rdata           (rdata)
  );

  // output register
  ind_btb_dout_reg ind_btb_dout_reg_inst (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .rd_issue        (rd_issue),
    .inv_on          (inv_on),
    .rdata           (rdata),
    .priv_mode       (priv_mode),
    .dout            (dout),
    .priv_out        (priv_out)
  );

endmodule

// ==== hw/ind_btb_dout_reg.sv ====
// indirect btb output register
`timescale 1ns/1ps

module ind_btb_dout_reg (
  input  logic                    dout_update_clk,
  input  logic                    cpurst_b,
  input  logic                    rd_issue,
  input  logic                    inv_on,
  input  ind_btb_pkg::btb_entry_t rdata,
  input  logic [1:0]              priv_mode,
  output ind_btb_pkg::btb_entry_t dout,
  output logic [1:0]              priv_out
);

  logic rd_flop;
  logic dout_capture;

  // ========================================
  // read in flight, lines up with array data
  // ========================================
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rd_flop <= 1'b0;
    else if (inv_on)
      rd_flop <= 1'b0;
    else
      rd_flop <= rd_issue;
  end

  // sweep start drops the pending read
  assign dout_capture = rd_flop && !inv_on;

  // ========================================
  // data and privilege snapshot
  // ========================================
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dout     <= '0;
      priv_out <= ind_btb_pkg::priv_machine;
    end
    else if (dout_capture)
    begin
      dout     <= rdata;
      // priv taken when the data lands
      priv_out <= priv_mode;
    end
  end

endmodule

// ==== hw/ind_btb_array.sv ====
// indirect btb table storage
`timescale 1ns/1ps

module ind_btb_array #(
  parameter int index_w = ind_btb_pkg::index_w
) (
  input  logic                    dout_update_clk,
  input  logic                    cpurst_b,
  input  ind_btb_pkg::btb_cmd_t   cmd,
  output ind_btb_pkg::btb_entry_t rdata
);

  localparam int depth = 2 ** index_w;

  // contents only defined after a sweep
  ind_btb_pkg::btb_entry_t mem [depth];

  // ========================================
  // write port
  // ========================================
  always_ff @(posedge dout_update_clk)
  begin
    if (cmd.wen)
      mem[cmd.index[index_w-1:0]] <= cmd.data;
  end

  // registered read, data one cycle after ren
  always_ff @(posedge dout_update_clk)
  begin
    if (cmd.ren)
      rdata <= mem[cmd.index[index_w-1:0]];
  end

  // write followed by a read of the same entry returns the new data
  a_wr_rd_through: assert property (
    @(posedge dout_update_clk) disable iff (!cpurst_b)
    $past(cmd.ren) && $past(cmd.wen, 2) &&
    ($past(cmd.index, 2) == $past(cmd.index)) |-> (rdata == $past(cmd.data, 2))
  ) else $error("table read did not return last written entry");

endmodule

// ==== hw/ind_btb_access_ctrl.sv ====
// table access arbitration and hashing
`timescale 1ns/1ps

module ind_btb_access_ctrl #(
  parameter int index_w = ind_btb_pkg::index_w
) (
  input  ind_btb_pkg::retire_bus_t retire,
  input  ind_btb_pkg::fetch_bus_t  fetch,
  input  logic                     flush,
  input  logic                     btb_en,
  input  logic                     fifo_stall,
  input  logic                     inv_on,
  input  logic [index_w-1:0]       inv_idx,
  input  ind_btb_pkg::path_hist_t  rtu_hist,
  input  ind_btb_pkg::path_hist_t  spec_hist_next,
  input  logic [index_w-1:0]       rtu_ghr,
  input  logic [index_w-1:0]       vghr,
  input  logic [1:0]               priv_mode,
  output ind_btb_pkg::btb_cmd_t    cmd,
  output logic                     rd_issue
);

  logic               wr_vld;
  logic               rd_req;
  logic [index_w-1:0] wr_index;
  logic [index_w-1:0] rd_index;

  // two bits per stage, xor with the matching ghr bits
  function automatic logic [index_w-1:0] hash_idx(
    input ind_btb_pkg::path_hist_t hist,
    input logic [index_w-1:0]      ghr
  );
    logic [index_w-1:0] idx;
    idx = '0;
    for (int k = 0; k < ind_btb_pkg::hist_depth; k++)
    begin
      idx[2*k +: 2] = hist.stage[k][2*k +: 2] ^ ghr[2*k +: 2];
    end
    return idx;
  endfunction

  // ========================================
  // request sources
  // ========================================
  // retire slot 0 mispredicted jump
  assign wr_vld   = btb_en && retire.jmp_mispred;
  // jump detect, fetch check, or recovery with a detected jump
  assign rd_req   = fetch.jmp_detect || fetch.check_vld ||
                    ((retire.mispred || flush) && fetch.jmp_detect);
  assign wr_index = hash_idx(rtu_hist, rtu_ghr);
  assign rd_index = hash_idx(spec_hist_next, vghr);

  // ========================================
  // fixed priority, sweep > write > read
  // ========================================
  always_comb
  begin
    cmd.wen   = 1'b0;
    cmd.ren   = 1'b0;
    cmd.index = rd_index;
    cmd.data  = '0;
    if (inv_on)
    begin
      // zero entry clears valid
      cmd.wen   = 1'b1;
      cmd.index = inv_idx;
    end
    else if (wr_vld)
    begin
      cmd.wen   = 1'b1;
      cmd.index = wr_index;
      cmd.data  = '{valid: 1'b1, priv: priv_mode, target: retire.target};
    end
    else if (btb_en && rd_req && !fifo_stall)
      cmd.ren = 1'b1;
  end

  assign rd_issue = cmd.ren;

  a_rd_wr_excl: assert property (
    @(posedge ind_btb_top.dout_update_clk) disable iff (!ind_btb_top.cpurst_b)
    !(cmd.wen && cmd.ren)
  ) else $error("table read and write issued together");

endmodule

// ==== hw/ind_btb_spec_path.sv ====
// speculative path history
`timescale 1ns/1ps

module ind_btb_spec_path (
  input  logic                    dout_update_clk,
  input  logic                    cpurst_b,
  input  ind_btb_pkg::fetch_bus_t fetch,
  input  logic                    flush,
  input  logic                    retire_mispred,
  input  logic                    btb_en,
  input  logic                    inv_on,
  input  ind_btb_pkg::path_hist_t rtu_hist_next,
  output ind_btb_pkg::path_hist_t spec_hist_next
);

  ind_btb_pkg::path_hist_t spec_hist;
  ind_btb_pkg::path_hist_t spec_push;
  logic                    spec_recover;

  // flush or retire mispredict
  assign spec_recover = retire_mispred || flush;

  // fetch path pushed into stage 0
  always_comb
  begin
    spec_push.stage[0] = fetch.path;
    for (int k = 1; k < ind_btb_pkg::hist_depth; k++)
    begin
      spec_push.stage[k] = spec_hist.stage[k-1];
    end
  end

  // ========================================
  // next value, feeds the read hash
  // ========================================
  // recovery wins over a fetch push
  assign spec_hist_next = spec_recover    ? rtu_hist_next :
                          fetch.check_vld ? spec_push     :
                                            spec_hist;

  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      spec_hist <= '0;
    else if (inv_on)
      spec_hist <= '0;
    else if (btb_en && (spec_recover || fetch.check_vld))
      spec_hist <= spec_hist_next;
  end

endmodule

// ==== hw/ind_btb_retire_path.sv ====
// retire side path history
`timescale 1ns/1ps

module ind_btb_retire_path (
  input  logic                     dout_update_clk,
  input  logic                     cpurst_b,
  input  ind_btb_pkg::retire_bus_t retire,
  input  logic                     btb_en,
  input  logic                     inv_on,
  output ind_btb_pkg::path_hist_t  rtu_hist,
  output ind_btb_pkg::path_hist_t  rtu_hist_next
);

  logic rtu_jmp_any;

  // ========================================
  // jump detect over all retire slots
  // ========================================
  always_comb
  begin
    rtu_jmp_any = 1'b0;
    for (int s = 0; s < ind_btb_pkg::retire_w; s++)
    begin
      rtu_jmp_any = rtu_jmp_any | retire.slot[s].jmp;
    end
  end

  // ========================================
  // next history
  // ========================================
  // slots shift in oldest first
  // so the youngest jumping slot lands in stage 0
  // covers every slot-jump pattern, none jumping keeps the value
  always_comb
  begin
    rtu_hist_next = rtu_hist;
    for (int s = 0; s < ind_btb_pkg::retire_w; s++)
    begin
      if (retire.slot[s].jmp)
      begin
        // older stages move up by one
        for (int k = ind_btb_pkg::hist_depth - 1; k > 0; k--)
        begin
          rtu_hist_next.stage[k] = rtu_hist_next.stage[k-1];
        end
        rtu_hist_next.stage[0] = retire.slot[s].chk_idx;
      end
    end
  end

  // ========================================
  // history register
  // ========================================
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rtu_hist <= '0;
    else if (inv_on)
      rtu_hist <= '0;
    else if (rtu_jmp_any && btb_en)
      rtu_hist <= rtu_hist_next;
  end

endmodule

// ==== hw/ind_btb_inv_ctrl.sv ====
// invalidation sweep control
`timescale 1ns/1ps

module ind_btb_inv_ctrl #(
  parameter int index_w = ind_btb_pkg::index_w
) (
  input  logic               dout_update_clk,
  input  logic               cpurst_b,
  input  logic               inv_req,
  output logic               inv_on,
  output logic               inv_ack,
  output logic [index_w-1:0] inv_idx
);

  logic               sweep_start;
  logic               sweep_last;
  logic [index_w-1:0] sweep_cnt;

  // new sweep only after the previous ack was dropped
  assign sweep_start = inv_req && !inv_ack && !inv_on;
  // final entry, index 0
  assign sweep_last  = inv_on && (sweep_cnt == '0);

  // ========================================
  // sweep counter and busy flag
  // ========================================
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      inv_on    <= 1'b0;
      sweep_cnt <= '0;
    end
    else if (sweep_start)
    begin
      inv_on    <= 1'b1;
      sweep_cnt <= '1;
    end
    else if (sweep_last)
      inv_on <= 1'b0;
    else if (inv_on)
      sweep_cnt <= sweep_cnt - 1'b1;
  end

  // ack up at sweep end, down once req is released
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      inv_ack <= 1'b0;
    else if (sweep_last)
      inv_ack <= 1'b1;
    else if (!inv_req)
      inv_ack <= 1'b0;
  end

  assign inv_idx = sweep_cnt;

  // ========================================
  // handshake checks
  // ========================================
  a_ack_not_during_sweep: assert property (
    @(posedge dout_update_clk) disable iff (!cpurst_b)
    !(inv_ack && inv_on)
  ) else $error("inv_ack high while sweep running");

endmodule

// ==== hw/ind_btb_pkg.sv ====
// indirect btb shared definitions
package ind_btb_pkg;

  // ========================================
  // widths and constants
  // ========================================
  // one path index from the fetch check logic
  localparam int path_w   = 8;
  // history stages, stage 0 newest
  localparam int hist_depth = 4;
  // retire slots per cycle
  localparam int retire_w = 3;
  // low target bits kept per entry
  localparam int target_w = 20;
  // table index, two bits per history stage
  localparam int index_w  = 8;
  // privilege snapshot comes out of reset in machine mode
  localparam logic [1:0] priv_machine = 2'b11;

  // ========================================
  // packed bundles
  // ========================================
  typedef struct packed {
    logic [hist_depth-1:0][path_w-1:0] stage;
  } path_hist_t;

  typedef struct packed {
    logic                valid;
    logic [1:0]          priv;
    logic [target_w-1:0] target;
  } btb_entry_t;

  typedef struct packed {
    logic              jmp;
    logic [path_w-1:0] chk_idx;
  } retire_slot_t;

  // slot 0 is the oldest retiring instruction
  typedef struct packed {
    retire_slot_t [retire_w-1:0] slot;
    logic                        mispred;
    logic                        jmp_mispred;
    logic [target_w-1:0]         target;
  } retire_bus_t;

  typedef struct packed {
    logic              jmp_detect;
    logic              check_vld;
    logic [path_w-1:0] path;
  } fetch_bus_t;

  typedef struct packed {
    logic               wen;
    logic               ren;
    logic [index_w-1:0] index;
    btb_entry_t         data;
  } btb_cmd_t;

endpackage
